//--- hdl/afifo_defs.svh
// Project-wide FIFO sizing macros; include wherever a width, depth or default margin is needed
`ifndef AFIFO_DEFS_SVH
`define AFIFO_DEFS_SVH

// ----------------------------------------------------------------------
// Storage geometry
// ----------------------------------------------------------------------

// Width of one stored word
`define AFIFO_DATA_WIDTH 8

// Index width; depth is always a power of two
`define AFIFO_ADDR_WIDTH 4
`define AFIFO_DEPTH      (1 << `AFIFO_ADDR_WIDTH)

// ----------------------------------------------------------------------
// Default flag margins
// ----------------------------------------------------------------------
`define AFIFO_WR_MARGIN  2
`define AFIFO_RD_MARGIN  2

`endif

//--- hdl/afifo_pkg.sv
// Shared vector types for the async FIFO; referenced by scoped name from RTL and testbench
`include "afifo_defs.svh"

package afifo_pkg;

    // ------------------------------------------------------------------
    // Payload and addressing
    // ------------------------------------------------------------------

    // One stored word
    typedef logic [`AFIFO_DATA_WIDTH-1:0] data_t;

    // Index into the storage array
    typedef logic [`AFIFO_ADDR_WIDTH-1:0] addr_t;

    // ------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------

    // Binary or Gray pointer, MSB is the wrap bit
    typedef logic [`AFIFO_ADDR_WIDTH:0]   ptr_t;

    // Occupancy 0 .. depth, needs the extra bit for a full FIFO
    typedef logic [`AFIFO_ADDR_WIDTH:0]   count_t;

endpackage : afifo_pkg

//--- hdl/fifo_async.sv
// Asynchronous FIFO top level, writes on wr_clk and reads on rd_clk with level enables
`timescale 1ns/100ps
`include "afifo_defs.svh"

module fifo_async #(
    parameter int ALMOST_WR_MARGIN = `AFIFO_WR_MARGIN,
    parameter int ALMOST_RD_MARGIN = `AFIFO_RD_MARGIN,
    parameter int REGISTERED       = 0
) (
    // Write side
    input  logic              wr_clk,
    input  logic              wr_rst_n,
    input  logic              wr_en,
    input  afifo_pkg::data_t  wr_data,
    // Read side
    input  logic              rd_clk,
    input  logic              rd_rst_n,
    input  logic              rd_en,
    output afifo_pkg::data_t  rd_data,
    // Status
    output logic              wr_full,
    output logic              wr_almost_full,
    output logic              rd_empty,
    output logic              rd_almost_empty,
    output afifo_pkg::count_t count
);

    // Own pointers
    afifo_pkg::ptr_t wr_ptr_bin;
    afifo_pkg::ptr_t wr_ptr_gray;
    afifo_pkg::ptr_t rd_ptr_bin;
    afifo_pkg::ptr_t rd_ptr_gray;
    // Pointers after crossing
    afifo_pkg::ptr_t rdom_wr_ptr_bin;
    afifo_pkg::ptr_t wdom_rd_ptr_bin;
    // Accepted accesses
    logic            wr_adv;
    logic            rd_adv;

    // ------------------------------------------------------------------
    // Pointer generators, full drops writes and empty ignores reads
    // ------------------------------------------------------------------
    fifo_ptr_gen u_wr_ptr (
        .clk      (wr_clk),
        .rst_n    (wr_rst_n),
        .en       (wr_en),
        .stop     (wr_full),
        .ptr_bin  (wr_ptr_bin),
        .ptr_gray (wr_ptr_gray),
        .adv      (wr_adv)
    );

    fifo_ptr_gen u_rd_ptr (
        .clk      (rd_clk),
        .rst_n    (rd_rst_n),
        .en       (rd_en),
        .stop     (rd_empty),
        .ptr_bin  (rd_ptr_bin),
        .ptr_gray (rd_ptr_gray),
        .adv      (rd_adv)
    );

    // ------------------------------------------------------------------
    // Clock crossings
    // ------------------------------------------------------------------

    // Write pointer into the read domain
    ptr_sync u_sync_wr2rd (
        .clk     (rd_clk),
        .rst_n   (rd_rst_n),
        .gray_in (wr_ptr_gray),
        .bin_out (rdom_wr_ptr_bin)
    );

    // Read pointer into the write domain
    ptr_sync u_sync_rd2wr (
        .clk     (wr_clk),
        .rst_n   (wr_rst_n),
        .gray_in (rd_ptr_gray),
        .bin_out (wdom_rd_ptr_bin)
    );

    // ------------------------------------------------------------------
    // Flags, count and storage
    // ------------------------------------------------------------------
    fifo_control #(
        .ALMOST_WR_MARGIN (ALMOST_WR_MARGIN),
        .ALMOST_RD_MARGIN (ALMOST_RD_MARGIN),
        .REGISTERED       (REGISTERED)
    ) u_fifo_control (
        .wr_clk          (wr_clk),
        .wr_rst_n        (wr_rst_n),
        .rd_clk          (rd_clk),
        .rd_rst_n        (rd_rst_n),
        .wr_ptr_bin      (wr_ptr_bin),
        .wdom_rd_ptr_bin (wdom_rd_ptr_bin),
        .rd_ptr_bin      (rd_ptr_bin),
        .rdom_wr_ptr_bin (rdom_wr_ptr_bin),
        .count           (count),
        .wr_full         (wr_full),
        .wr_almost_full  (wr_almost_full),
        .rd_empty        (rd_empty),
        .rd_almost_empty (rd_almost_empty)
    );

    // Index bits only, the wrap bit stays with the pointers
    fifo_mem #(
        .REGISTERED (REGISTERED)
    ) u_fifo_mem (
        .wr_clk   (wr_clk),
        .wr_en    (wr_adv),
        .wr_addr  (wr_ptr_bin[`AFIFO_ADDR_WIDTH-1:0]),
        .wr_data  (wr_data),
        .rd_clk   (rd_clk),
        .rd_rst_n (rd_rst_n),
        .rd_adv   (rd_adv),
        .rd_addr  (rd_ptr_bin[`AFIFO_ADDR_WIDTH-1:0]),
        .rd_data  (rd_data)
    );

endmodule : fifo_async

//--- hdl/fifo_control.sv
// Full, almost-full, empty and almost-empty flags plus read-side count from binary pointers
`timescale 1ns/100ps
`include "afifo_defs.svh"

module fifo_control #(
    parameter int ALMOST_WR_MARGIN = `AFIFO_WR_MARGIN,
    parameter int ALMOST_RD_MARGIN = `AFIFO_RD_MARGIN,
    parameter int REGISTERED       = 0
) (
    // Clocks and resets
    input  logic              wr_clk,
    input  logic              wr_rst_n,
    input  logic              rd_clk,
    input  logic              rd_rst_n,
    // Own and synchronized pointers of each domain
    input  afifo_pkg::ptr_t   wr_ptr_bin,
    input  afifo_pkg::ptr_t   wdom_rd_ptr_bin,
    input  afifo_pkg::ptr_t   rd_ptr_bin,
    input  afifo_pkg::ptr_t   rdom_wr_ptr_bin,
    // Status
    output afifo_pkg::count_t count,
    output logic              wr_full,
    output logic              wr_almost_full,
    output logic              rd_empty,
    output logic              rd_almost_empty
);

    localparam int AW  = `AFIFO_ADDR_WIDTH;
    // Almost-full threshold, entries used
    localparam int AFT = `AFIFO_DEPTH - ALMOST_WR_MARGIN;
    // Almost-empty threshold, entries used
    localparam int AET = ALMOST_RD_MARGIN;

    logic              wr_wrap_diff;
    logic              rd_wrap_diff;
    afifo_pkg::count_t wr_used;
    afifo_pkg::ptr_t   wr_ptr_for_empty;
    logic              wr_almost_full_d;
    logic              rd_almost_empty_d;

    // ------------------------------------------------------------------
    // Write domain
    // ------------------------------------------------------------------

    // Wrap bits differ when the writer is one lap ahead
    assign wr_wrap_diff = wr_ptr_bin[AW] ^ wdom_rd_ptr_bin[AW];

    // Full when one lap ahead at the same index
    // Decoded from the pointer flops, so a filling write blocks the very next edge
    assign wr_full = wr_wrap_diff && (wr_ptr_bin[AW-1:0] == wdom_rd_ptr_bin[AW-1:0]);

    // Modulo difference of the wrapped pointers gives 0 .. depth
    assign wr_used = afifo_pkg::count_t'(wr_ptr_bin - wdom_rd_ptr_bin);

    assign wr_almost_full_d = wr_used >= afifo_pkg::count_t'(AFT);

    always_ff @(posedge wr_clk, negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_almost_full <= 1'b0;
        end else begin
            wr_almost_full <= wr_almost_full_d;
        end
    end

    // ------------------------------------------------------------------
    // Read domain
    // ------------------------------------------------------------------

    // Flop mode sees new data one cycle late through the output register
    generate
        if (REGISTERED == 1) begin : gen_flop_mode
            afifo_pkg::ptr_t rdom_wr_ptr_dly;

            always_ff @(posedge rd_clk, negedge rd_rst_n) begin
                if (!rd_rst_n) begin
                    rdom_wr_ptr_dly <= '0;
                end else begin
                    rdom_wr_ptr_dly <= rdom_wr_ptr_bin;
                end
            end

            assign wr_ptr_for_empty = rdom_wr_ptr_dly;
        end else begin : gen_mux_mode
            // Data is visible as soon as the pointer arrives
            assign wr_ptr_for_empty = rdom_wr_ptr_bin;
        end
    endgenerate

    assign rd_wrap_diff = rd_ptr_bin[AW] ^ wr_ptr_for_empty[AW];

    // Empty when on the same lap at the same index
    // A pop that drains the FIFO blocks the next edge right away
    assign rd_empty = !rd_wrap_diff && (rd_ptr_bin[AW-1:0] == wr_ptr_for_empty[AW-1:0]);

    // Occupancy seen by the reader
    assign count = afifo_pkg::count_t'(rdom_wr_ptr_bin - rd_ptr_bin);

    assign rd_almost_empty_d = count <= afifo_pkg::count_t'(AET);

    always_ff @(posedge rd_clk, negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_almost_empty <= 1'b0;
        end else begin
            rd_almost_empty <= rd_almost_empty_d;
        end
    end

endmodule : fifo_control

//--- hdl/fifo_mem.sv
// Dual-port FIFO storage, written on wr_clk and read as a mux or through a register on rd_clk
`timescale 1ns/100ps
`include "afifo_defs.svh"

module fifo_mem #(
    parameter int REGISTERED = 0
) (
    input  logic             wr_clk,
    input  logic             wr_en,
    input  afifo_pkg::addr_t wr_addr,
    input  afifo_pkg::data_t wr_data,
    input  logic             rd_clk,
    input  logic             rd_rst_n,
    input  logic             rd_adv,
    input  afifo_pkg::addr_t rd_addr,
    output afifo_pkg::data_t rd_data
);

    afifo_pkg::data_t mem [`AFIFO_DEPTH];

    // Write port
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------
    generate
        if (REGISTERED == 1) begin : gen_flop_mode
            afifo_pkg::addr_t rd_addr_next;
            afifo_pkg::data_t rd_data_q;

            assign rd_addr_next = rd_addr + 1'b1;

            // On a pop, fetch the word behind the head so it shows next cycle
            always_ff @(posedge rd_clk, negedge rd_rst_n) begin
                if (!rd_rst_n) begin
                    rd_data_q <= '0;
                end else if (rd_adv) begin
                    rd_data_q <= mem[rd_addr_next];
                end else begin
                    rd_data_q <= mem[rd_addr];
                end
            end

            assign rd_data = rd_data_q;
        end else begin : gen_mux_mode
            // Show-ahead, head word always on the output
            assign rd_data = mem[rd_addr];
        end
    endgenerate

endmodule : fifo_mem

//--- hdl/fifo_ptr_gen.sv
// Per-domain FIFO pointer with full/empty gating and a Gray copy for the clock crossing
`timescale 1ns/100ps

module fifo_ptr_gen (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic            stop,
    output afifo_pkg::ptr_t ptr_bin,
    output afifo_pkg::ptr_t ptr_gray,
    output logic            adv
);

    // Gray form of the current binary pointer
    afifo_pkg::ptr_t gray_d;

    // Request only counts when the inhibiting flag is clear
    // (full on the write side, empty on the read side)
    assign adv = en && !stop;

    // Binary pointer, steps on the same edge that takes the access
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            ptr_bin <= '0;
        end else if (adv) begin
            ptr_bin <= ptr_bin + 1'b1;
        end
    end

    // Adjacent binary values differ in one Gray bit
    assign gray_d = ptr_bin ^ (ptr_bin >> 1);

    // Registered Gray copy, trails the binary pointer by a cycle
    // Only this flop feeds the other domain, so no glitches cross
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            ptr_gray <= '0;
        end else begin
            ptr_gray <= gray_d;
        end
    end

endmodule : fifo_ptr_gen

//--- hdl/ptr_sync.sv
// Brings a Gray pointer into the destination clock domain and converts it back to binary
`timescale 1ns/100ps

module ptr_sync (
    input  logic            clk,
    input  logic            rst_n,
    input  afifo_pkg::ptr_t gray_in,
    output afifo_pkg::ptr_t bin_out
);

    // First stage may go metastable, second stage is the settled copy
    afifo_pkg::ptr_t gray_meta;
    afifo_pkg::ptr_t gray_sync;

    // ------------------------------------------------------------------
    // Two-flop synchronizer in the destination domain
    // ------------------------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            gray_meta <= '0;
            gray_sync <= '0;
        end else begin
            gray_meta <= gray_in;
            gray_sync <= gray_meta;
        end
    end

    // ------------------------------------------------------------------
    // Gray to binary
    // ------------------------------------------------------------------

    // Each binary bit is the XOR of its Gray bit and all bits above it
    // MSB passes straight through
    always_comb begin
        for (int i = 0; i < $bits(afifo_pkg::ptr_t); i++) begin
            bin_out[i] = ^(gray_sync >> i);
        end
    end

endmodule : ptr_sync

//--- run_sim.sh
#!/bin/sh
# Build and run the async FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module fifo_async_tb -o fifo_async_sim || exit 1
out=$(./obj_dir/fifo_async_sim 2>&1)
echo "$out"
echo "$out" | grep -qF '** PASS **' && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

//--- sources.f
+incdir+hdl
hdl/afifo_pkg.sv
hdl/fifo_ptr_gen.sv
hdl/ptr_sync.sv
hdl/fifo_control.sv
hdl/fifo_mem.sv
hdl/fifo_async.sv
test/fifo_async_chk.sv
test/fifo_async_tb.sv

//--- test/fifo_async_chk.sv
// Concurrent assertions on the async FIFO pointers and flags, bound into the top level
`timescale 1ns/100ps
`include "afifo_defs.svh"

module fifo_async_chk (
    input logic              wr_clk,
    input logic              wr_rst_n,
    input logic              rd_clk,
    input logic              rd_rst_n,
    input logic              wr_full,
    input logic              rd_empty,
    input afifo_pkg::ptr_t   wr_ptr_bin,
    input afifo_pkg::ptr_t   rd_ptr_bin,
    input afifo_pkg::count_t count
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // Occupancy can never go past the depth
    a_count_range: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        count <= `AFIFO_DEPTH)
    else begin
        fail_count++;
        $error("count above FIFO depth");
    end

    // Dropped write leaves the write pointer alone
    a_wr_hold: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
        wr_full |=> $stable(wr_ptr_bin))
    else begin
        fail_count++;
        $error("write pointer moved while full");
    end

    // Ignored read leaves the read pointer alone
    a_rd_hold: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        rd_empty |=> $stable(rd_ptr_bin))
    else begin
        fail_count++;
        $error("read pointer moved while empty");
    end

    a_empty_after_reset: assert property (@(posedge rd_clk)
        $rose(rd_rst_n) |-> rd_empty)
    else begin
        fail_count++;
        $error("rd_empty low right after reset");
    end

endmodule : fifo_async_chk

//--- test/fifo_async_tb.sv
// Two-clock testbench for the async FIFO; runs a table of operations against a queue model
`timescale 1ns/100ps
`include "afifo_defs.svh"

module fifo_async_tb;

    // Operation kind of one table row
    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_MIXED, OP_IDLE} op_e;

    // One table row
    // An exp_count of -1 leaves the settled count to the model alone
    typedef struct packed {
        op_e kind;
        int  words;
        int  exp_count;
    } row_t;

    localparam int          N_ROWS    = 10;
    localparam int          SETTLE    = 8;
    localparam int          RST_LEN   = 10;
    localparam int unsigned SEED      = 32'hea35_21cc;

    logic              wr_clk;
    logic              wr_rst_n;
    logic              wr_en;
    afifo_pkg::data_t  wr_data;
    logic              rd_clk;
    logic              rd_rst_n;
    logic              rd_en;
    afifo_pkg::data_t  rd_data;
    logic              wr_full;
    logic              wr_almost_full;
    logic              rd_empty;
    logic              rd_almost_empty;
    afifo_pkg::count_t count;

    row_t              rows [N_ROWS];
    afifo_pkg::data_t  model [$];
    afifo_pkg::data_t  next_word = '0;
    int unsigned       pops = 0;
    int unsigned       cycles = 0;
    int unsigned       cycle_limit = 0;

    fifo_async #(
        .ALMOST_WR_MARGIN (2),
        .ALMOST_RD_MARGIN (2),
        .REGISTERED       (0)
    ) i_fifo_async (
        .wr_clk          (wr_clk),
        .wr_rst_n        (wr_rst_n),
        .wr_en           (wr_en),
        .wr_data         (wr_data),
        .rd_clk          (rd_clk),
        .rd_rst_n        (rd_rst_n),
        .rd_en           (rd_en),
        .rd_data         (rd_data),
        .wr_full         (wr_full),
        .wr_almost_full  (wr_almost_full),
        .rd_empty        (rd_empty),
        .rd_almost_empty (rd_almost_empty),
        .count           (count)
    );

    // Assertion module sees the internal pointers of the top level
    bind fifo_async fifo_async_chk u_chk (
        .wr_clk     (wr_clk),
        .wr_rst_n   (wr_rst_n),
        .rd_clk     (rd_clk),
        .rd_rst_n   (rd_rst_n),
        .wr_full    (wr_full),
        .rd_empty   (rd_empty),
        .wr_ptr_bin (wr_ptr_bin),
        .rd_ptr_bin (rd_ptr_bin),
        .count      (count)
    );

    // ------------------------------------------------------------------
    // Clock periods chosen so the rising edges never coincide
    // ------------------------------------------------------------------
    initial begin
        rd_clk = 1'b0;
        forever #10 rd_clk = ~rd_clk;
    end

    initial begin
        wr_clk = 1'b0;
        forever #7 wr_clk = ~wr_clk;
    end

    // ------------------------------------------------------------------
    // Failure reporting and typed compares
    // ------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input string name, input afifo_pkg::data_t exp,
                              input afifo_pkg::data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input string name, input afifo_pkg::count_t exp,
                               input afifo_pkg::count_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model sampling the same pre-edge values as the DUT
    // ------------------------------------------------------------------

    // Accepted write goes to the back of the model
    always @(posedge wr_clk) begin
        if (wr_rst_n && wr_en && !wr_full) begin
            model.push_back(wr_data);
        end
    end

    // Show-ahead output must equal the model head on every accepted pop
    always @(posedge rd_clk) begin
        if (rd_rst_n && rd_en && !rd_empty) begin
            if (model.size() == 0) begin
                $display("DUT accepted a read while the reference model was empty");
                stop_with_failure();
            end else begin
                check_data($sformatf("pop %0d", pops), model[0], rd_data);
                void'(model.pop_front());
                pops++;
            end
        end
    end

    // Watchdog in read clock cycles
    always @(posedge rd_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run went past %0d read clock cycles", cycle_limit);
            stop_with_failure();
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic fill_table();
        rows[0] = '{OP_READ,   3,  0};   // read on an empty FIFO is ignored
        rows[1] = '{OP_WRITE, 10, 10};
        rows[2] = '{OP_READ,  10,  0};   // order check
        rows[3] = '{OP_WRITE, 18, 16};   // last two words dropped
        rows[4] = '{OP_READ,  16,  0};
        rows[5] = '{OP_WRITE,  3,  3};
        rows[6] = '{OP_WRITE, 11, 14};   // almost full
        rows[7] = '{OP_READ,  12,  2};   // almost empty
        rows[8] = '{OP_MIXED, 200, -1};
        rows[9] = '{OP_READ,  20,  0};   // drain
    endtask

    // Twice the rows plus settle idles
    function automatic int unsigned run_length();
        int unsigned total;
        total = RST_LEN;
        for (int r = 0; r < N_ROWS; r++) begin
            total += rows[r].words + 2 * SETTLE;
        end
        return 2 * total;
    endfunction

    task automatic drive_writes(input op_e kind, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge wr_clk);
            case (kind)
                OP_WRITE: begin
                    wr_en     <= 1'b1;
                    wr_data   <= next_word;
                    next_word = afifo_pkg::data_t'(next_word + 1);
                end
                OP_MIXED: begin
                    wr_en   <= 1'($urandom_range(1, 0));
                    wr_data <= afifo_pkg::data_t'($urandom);
                end
                default: wr_en <= 1'b0;
            endcase
        end
        @(posedge wr_clk);
        wr_en <= 1'b0;
    endtask

    task automatic drive_reads(input op_e kind, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge rd_clk);
            case (kind)
                OP_READ:  rd_en <= 1'b1;
                OP_MIXED: rd_en <= 1'($urandom_range(1, 0));
                default:  rd_en <= 1'b0;
            endcase
        end
        @(posedge rd_clk);
        rd_en <= 1'b0;
    endtask

    // Flags and count once the crossings have caught up
    // Sampled on a falling read edge, away from every rising edge
    task automatic check_settled(input int r);
        string             name;
        afifo_pkg::count_t exp;
        repeat (SETTLE) @(posedge wr_clk);
        repeat (SETTLE) @(posedge rd_clk);
        @(negedge rd_clk);
        name = $sformatf("row %0d", r);
        exp  = afifo_pkg::count_t'(model.size());
        if (rows[r].exp_count >= 0) begin
            check_count({name, " table count"}, afifo_pkg::count_t'(rows[r].exp_count), count);
        end
        check_count({name, " model count"}, exp, count);
        check_flag({name, " wr_full"}, exp == `AFIFO_DEPTH, wr_full);
        check_flag({name, " wr_almost_full"}, exp >= `AFIFO_DEPTH - `AFIFO_WR_MARGIN,
                   wr_almost_full);
        check_flag({name, " rd_almost_empty"}, exp <= `AFIFO_RD_MARGIN, rd_almost_empty);
        check_flag({name, " rd_empty"}, exp == 0, rd_empty);
    endtask

    initial begin
        wr_rst_n = 1'b0;
        rd_rst_n = 1'b0;
        wr_en    = 1'b0;
        wr_data  = '0;
        rd_en    = 1'b0;
        void'($urandom(SEED));
        fill_table();
        cycle_limit = run_length();

        // Both resets held for ten read cycles
        repeat (RST_LEN) @(posedge rd_clk);
        rd_rst_n <= 1'b1;
        @(posedge wr_clk);
        wr_rst_n <= 1'b1;

        @(negedge rd_clk);
        check_flag("reset rd_empty", 1'b1, rd_empty);
        check_flag("reset wr_full", 1'b0, wr_full);
        check_count("reset count", '0, count);

        for (int r = 0; r < N_ROWS; r++) begin
            fork
                drive_writes(rows[r].kind, rows[r].words);
                drive_reads(rows[r].kind, rows[r].words);
            join
            check_settled(r);
        end

        if (i_fifo_async.u_chk.fail_count != 0) begin
            $display("Concurrent assertions failed %0d times", i_fifo_async.u_chk.fail_count);
            stop_with_failure();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule : fifo_async_tb
